// File: src.f
+incdir+.
bridge_pkg.sv
video_pkg.sv
bridge_port.sv
core_reset_ctrl.sv
video_output.sv
core_top.sv
core_top_assertions.sv
core_top_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the core_top testbench with Verilator, run it, then check the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module core_top_tb \
  --Mdir obj_dir -o core_top_tb_sim &&
./obj_dir/core_top_tb_sim +verilator+error+limit+1000 > sim.log 2>&1 ||
echo "build or simulation returned an error"
cat sim.log 2>/dev/null
grep -q '^All tests passed!$' sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: core_top_tb.sv
// Testbench for the core top level.
// Drives bridge, data slot, host reset, start key and video on the falling
// edge; a comparing process checks every output against reference models.

`timescale 1ns/1ps

`include "core_settings.svh"

module core_top_tb;

  // cycles allowed for the start press to reach the hold timer
  localparam int HOLD_WAIT = 20;

  logic                      clk_74a = 1'b0;
  logic                      rst;
  logic [`CORE_BRIDGE_W-1:0] bridge_addr;
  logic [`CORE_BRIDGE_W-1:0] bridge_wr_data;
  logic [`CORE_BRIDGE_W-1:0] bridge_rd_data;
  logic [`CORE_BRIDGE_W-1:0] cont1_key;
  logic                      bridge_wr;
  logic                      dataslot_requestwrite;
  logic                      dataslot_allcomplete;
  logic                      host_reset_n;
  logic                      core_reset;
  logic                      video_de;
  logic                      video_hs;
  logic                      video_vs;
  video_pkg::video_in_t      video_in;
  video_pkg::rgb888_t        video_rgb;
  bridge_pkg::loader_write_t load_write;

  // model state and counters
  logic  download_model = 1'b0;
  logic  status_known = 1'b1;
  int    checks = 0;
  int    errors = 0;
  int    beats_seen = 0;
  int    beats_exp = 0;
  string test_name = "reset";

  core_top uut (.*);

  bind core_top core_top_assertions u_assertions (
    .*, .load_en(load_write.en), .download(status.download)
  );

  initial begin
    forever #10 clk_74a = ~clk_74a;
  end

  ////////////////////////////////////////////////////////////////////////////
  // reference models

  // fill 8 bits by repeating a w bit channel from its msb downward
  function automatic logic [7:0] replicate_bits(input logic [5:0] c, input int w);
    logic [7:0] r;
    for (int i = 0; i < 8; i++) begin
      r[7-i] = c[w-1-(i % w)];
    end
    return r;
  endfunction

  // black outside de
  function automatic video_pkg::rgb888_t expand_pixel(input video_pkg::video_in_t v);
    video_pkg::rgb888_t p;
    p = '0;
    if (v.de) begin
      p.r8 = replicate_bits(6'(v.pixel.r5), 5);
      p.g8 = replicate_bits(v.pixel.g6, 6);
      p.b8 = replicate_bits(6'(v.pixel.b5), 5);
    end
    return p;
  endfunction

  // status in the command region only
  function automatic logic [31:0] read_word(input logic [31:0] addr,
                                            input bridge_pkg::core_status_t s);
    return (addr[31:24] == `CORE_CMD_REGION) ? {29'b0, s} : 32'b0;
  endfunction

  function automatic bridge_pkg::loader_write_t load_beat(input logic wr,
      input logic [31:0] addr, input logic [31:0] data);
    bridge_pkg::loader_write_t b;
    b.en   = wr && (addr[31:24] == `CORE_LOADER_REGION);
    b.addr = addr[`CORE_LOAD_ADDR_W-1:0];
    b.data = data;
    return b;
  endfunction

  // pick the loader, command or another region with equal weight
  function automatic logic [31:0] random_addr();
    logic [7:0] hi;
    case ($urandom_range(2, 0))
      0:       hi = `CORE_LOADER_REGION;
      1:       hi = `CORE_CMD_REGION;
      default: hi = 8'h20 + 8'($urandom_range(200, 0));
    endcase
    return {hi, 24'($urandom)};
  endfunction

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("mismatch %s %s: expected %h, actual %h", test_name, what, expected, actual);
    end
  endtask

  // one-cycle strobe that returns on the next falling edge
  task automatic pulse_dataslot(input logic req, input logic done);
    dataslot_requestwrite = req;
    dataslot_allcomplete  = done;
    @(negedge clk_74a);
    dataslot_requestwrite = 1'b0;
    dataslot_allcomplete  = 1'b0;
  endtask

  task automatic report_test(input int errors_before);
    $display("test %s done, %0d errors", test_name, errors - errors_before);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // comparing process

  initial begin : compare_outputs
    bridge_pkg::loader_write_t exp_load;
    bridge_pkg::core_status_t  exp_status;
    forever begin
      @(posedge clk_74a);
      // mid high phase where registers have settled and inputs are those just sampled
      #5;
      if (rst) begin
        download_model = 1'b0;
      end else begin
        // set beats clear
        download_model = dataslot_requestwrite | (download_model & ~dataslot_allcomplete);
        exp_load = load_beat(bridge_wr, bridge_addr, bridge_wr_data);
        beats_seen += int'(load_write.en);
        check_value("load en", 32'(exp_load.en), 32'(load_write.en));
        if (exp_load.en) begin
          check_value("load addr", 32'(exp_load.addr), 32'(load_write.addr));
          check_value("load data", exp_load.data, load_write.data);
        end
        // hold timer start is not modelled so these wait while it runs
        if (status_known) begin
          exp_status.download    = download_model;
          exp_status.hold_active = 1'b0;
          exp_status.core_reset  = ~host_reset_n | download_model;
          check_value("core reset", 32'(exp_status.core_reset), 32'(core_reset));
          check_value("read data", read_word(bridge_addr, exp_status), bridge_rd_data);
        end
        check_value("rgb", 32'(expand_pixel(video_in)), 32'(video_rgb));
        check_value("syncs", {video_in.de, video_in.hs, video_in.vs},
                    {video_de, video_hs, video_vs});
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus

  initial begin : stimulus
    int          e0;
    int          waited;
    int          held;
    logic [31:0] rnd;
    rnd = $urandom(33828);
    rst = 1'b1;
    bridge_addr = '0;
    bridge_wr = 1'b0;
    bridge_wr_data = '0;
    dataslot_requestwrite = 1'b0;
    dataslot_allcomplete = 1'b0;
    host_reset_n = 1'b1;
    cont1_key = '0;
    video_in = '0;
    repeat (5) @(negedge clk_74a);
    rst = 1'b0;

    // loader writes mixed with other regions and idle gaps
    test_name = "load_window";
    e0 = errors;
    for (int i = 0; i < 200; i++) begin
      if ($urandom_range(3, 0) == 0) begin
        bridge_wr = 1'b0;
        @(negedge clk_74a);
      end
      bridge_addr = random_addr();
      bridge_wr_data = $urandom;
      bridge_wr = 1'b1;
      beats_exp += int'(bridge_addr[31:24] == `CORE_LOADER_REGION);
      @(negedge clk_74a);
    end
    bridge_wr = 1'b0;
    @(negedge clk_74a);
    check_value("beat count", beats_exp, beats_seen);
    report_test(e0);

    // random reads while the download flag moves
    test_name = "read_mux";
    e0 = errors;
    for (int i = 0; i < 200; i++) begin
      bridge_addr = random_addr();
      dataslot_requestwrite = ($urandom_range(7, 0) == 0);
      dataslot_allcomplete = ($urandom_range(7, 0) == 0);
      @(negedge clk_74a);
    end
    pulse_dataslot(1'b0, 1'b1);
    report_test(e0);

    test_name = "download_flag";
    e0 = errors;
    bridge_addr = {`CORE_CMD_REGION, 24'h0};
    pulse_dataslot(1'b1, 1'b0);
    check_value("set core reset", 1, 32'(core_reset));
    check_value("set status", 1, 32'(bridge_rd_data[0]));
    pulse_dataslot(1'b0, 1'b1);
    check_value("clear core reset", 0, 32'(core_reset));
    check_value("clear status", 0, 32'(bridge_rd_data[0]));
    pulse_dataslot(1'b1, 1'b1);
    check_value("both status", 1, 32'(bridge_rd_data[0]));
    pulse_dataslot(1'b0, 1'b1);
    report_test(e0);

    // core reset follows host reset in the same cycle
    test_name = "host_reset";
    e0 = errors;
    host_reset_n = 1'b0;
    for (int i = 0; i < 50; i++) begin
      bridge_addr = random_addr();
      dataslot_requestwrite = ($urandom_range(3, 0) == 0);
      dataslot_allcomplete = ($urandom_range(3, 0) == 0);
      #1;
      check_value("forced reset", 1, 32'(core_reset));
      @(negedge clk_74a);
    end
    host_reset_n = 1'b1;
    pulse_dataslot(1'b0, 1'b1);
    report_test(e0);

    // press start and watch hold_active in the status word
    test_name = "reset_hold";
    e0 = errors;
    status_known = 1'b0;
    bridge_addr = {`CORE_CMD_REGION, 24'h0};
    cont1_key[15] = 1'b1;
    waited = 0;
    while (!bridge_rd_data[1] && waited < HOLD_WAIT) begin
      @(negedge clk_74a);
      waited++;
    end
    if (!bridge_rd_data[1]) begin
      errors++;
      $display("timeout: hold_active never rose after the start press");
    end else begin
      held = 0;
      while (core_reset && held < `CORE_RESET_HOLD + 100) begin
        held++;
        @(negedge clk_74a);
      end
      check_value("hold cycles", `CORE_RESET_HOLD, held);
      // start still held so no second hold
      for (int i = 0; i < 50; i++) begin
        check_value("no retrigger", 0, 32'(core_reset));
        @(negedge clk_74a);
      end
    end
    cont1_key = '0;
    repeat (5) @(negedge clk_74a);
    status_known = 1'b1;
    report_test(e0);

    test_name = "video";
    e0 = errors;
    for (int i = 0; i < 300; i++) begin
      rnd = $urandom;
      video_in = rnd[$bits(video_pkg::video_in_t)-1:0];
      @(negedge clk_74a);
    end
    video_in = '0;
    @(negedge clk_74a);
    report_test(e0);

    if (uut.u_assertions.assert_fails != 0) begin
      errors += uut.u_assertions.assert_fails;
      $display("bound assertions failed %0d times", uut.u_assertions.assert_fails);
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: core_top_assertions.sv
// Concurrent checks bound onto the core top level.
// Load beat timing, video blanking and the download clear.

`timescale 1ns/1ps

`include "core_settings.svh"

module core_top_assertions (
  input logic                      clk_74a,
  input logic                      rst,
  input logic [`CORE_BRIDGE_W-1:0] bridge_addr,
  input logic                      bridge_wr,
  input logic                      load_en,
  input video_pkg::rgb888_t        video_rgb,
  input logic                      video_de,
  input logic                      dataslot_requestwrite,
  input logic                      dataslot_allcomplete,
  input logic                      download
);

  // running count of failed assertions
  int assert_fails = 0;

  logic loader_wr;

  // write into the loader window this cycle
  assign loader_wr = bridge_wr && (bridge_addr[`CORE_BRIDGE_W-1 -: 8] == `CORE_LOADER_REGION);

  ////////////////////////////////////////////////////////////////////////////
  // load stream

  a_beat_after_write: assert property (
    @(posedge clk_74a) disable iff (rst) loader_wr |=> load_en
  ) else begin
    $error("no load beat after a loader window write");
    assert_fails++;
  end

  a_no_stray_beat: assert property (
    @(posedge clk_74a) disable iff (rst) !loader_wr |=> !load_en
  ) else begin
    $error("load beat without a loader window write");
    assert_fails++;
  end

  // blanked outside display enable
  a_blank: assert property (
    @(posedge clk_74a) disable iff (rst) !video_de |-> (video_rgb == '0)
  ) else begin
    $error("video_rgb not zero while video_de is low");
    assert_fails++;
  end

  a_download_clear: assert property (
    @(posedge clk_74a) disable iff (rst)
      (dataslot_allcomplete && !dataslot_requestwrite) |=> !download
  ) else begin
    $error("download still set after allcomplete");
    assert_fails++;
  end

endmodule

// File: core_top.sv
// Top level of the core, everything on clk_74a.
// Bridge port, reset control and video output, wired to the host
// bridge, the data slot strobes, controller 1 and the scaler.

`timescale 1ns/1ps

`include "core_settings.svh"

module core_top (
  input  logic                      clk_74a,
  input  logic                      rst,

  // host bridge
  input  logic [`CORE_BRIDGE_W-1:0] bridge_addr,
  input  logic                      bridge_wr,
  input  logic [`CORE_BRIDGE_W-1:0] bridge_wr_data,
  output logic [`CORE_BRIDGE_W-1:0] bridge_rd_data,

  // data slot strobes and host reset
  input  logic                      dataslot_requestwrite,
  input  logic                      dataslot_allcomplete,
  input  logic                      host_reset_n,

  // controller 1 key bitmap, async
  input  logic [`CORE_BRIDGE_W-1:0] cont1_key,

  // source video
  input  video_pkg::video_in_t      video_in,

  // load stream and core reset
  output bridge_pkg::loader_write_t load_write,
  output logic                      core_reset,

  // scaler video
  output video_pkg::rgb888_t        video_rgb,
  output logic                      video_de,
  output logic                      video_hs,
  output logic                      video_vs
);

  bridge_pkg::core_status_t status;

  ////////////////////////////////////////////////////////////////////////////
  // bridge

  bridge_port u_bridge_port (
    .clk_74a        (clk_74a),
    .rst            (rst),
    .bridge_addr    (bridge_addr),
    .bridge_wr      (bridge_wr),
    .bridge_wr_data (bridge_wr_data),
    .status         (status),
    .bridge_rd_data (bridge_rd_data),
    .load_write     (load_write)
  );

  ////////////////////////////////////////////////////////////////////////////
  // reset

  core_reset_ctrl u_core_reset_ctrl (
    .clk_74a               (clk_74a),
    .rst                   (rst),
    .dataslot_requestwrite (dataslot_requestwrite),
    .dataslot_allcomplete  (dataslot_allcomplete),
    .host_reset_n          (host_reset_n),
    .cont1_key             (cont1_key),
    .status                (status),
    .core_reset            (core_reset)
  );

  ////////////////////////////////////////////////////////////////////////////
  // video

  video_output u_video_output (
    .clk_74a   (clk_74a),
    .rst       (rst),
    .video_in  (video_in),
    .video_rgb (video_rgb),
    .video_de  (video_de),
    .video_hs  (video_hs),
    .video_vs  (video_vs)
  );

endmodule

// File: video_output.sv
// Video output stage toward the scaler.
// Expands RGB565 to RGB888, blanks outside display enable and registers
// pixel and syncs together, one cycle of latency.

`timescale 1ns/1ps

module video_output (
  input  logic                 clk_74a,
  input  logic                 rst,
  input  video_pkg::video_in_t video_in,
  output video_pkg::rgb888_t   video_rgb,
  output logic                 video_de,
  output logic                 video_hs,
  output logic                 video_vs
);

  video_pkg::rgb888_t rgb_next;

  // 5 bit channel to 8, top bits fill the low end
  function automatic logic [7:0] expand_5(input logic [4:0] c);
    return {c, c[4:2]};
  endfunction

  // 6 bit green to 8
  function automatic logic [7:0] expand_6(input logic [5:0] c);
    return {c, c[5:4]};
  endfunction

  // blank to black outside active display
  always_comb begin
    if (video_in.de) begin
      rgb_next.r8 = expand_5(video_in.pixel.r5);
      rgb_next.g8 = expand_6(video_in.pixel.g6);
      rgb_next.b8 = expand_5(video_in.pixel.b5);
    end else begin
      rgb_next = '0;
    end
  end

  // one stage, pixel and syncs stay aligned
  always_ff @(posedge clk_74a) begin
    if (rst) begin
      video_rgb <= '0;
      video_de  <= 1'b0;
      video_hs  <= 1'b0;
      video_vs  <= 1'b0;
    end else begin
      video_rgb <= rgb_next;
      video_de  <= video_in.de;
      video_hs  <= video_in.hs;
      video_vs  <= video_in.vs;
    end
  end

endmodule

// File: core_reset_ctrl.sv
// Core reset control in the clk_74a domain.
// Combines host reset, the data slot download flag and a hold timer
// started by the controller start button into one core reset.

`timescale 1ns/1ps

`include "core_settings.svh"

module core_reset_ctrl (
  input  logic                      clk_74a,
  input  logic                      rst,
  input  logic                      dataslot_requestwrite,
  input  logic                      dataslot_allcomplete,
  input  logic                      host_reset_n,
  input  logic [`CORE_BRIDGE_W-1:0] cont1_key,
  output bridge_pkg::core_status_t  status,
  output logic                      core_reset
);

  // face_start in the key bitmap
  localparam int START_BIT = 15;
  localparam int SYNC_N    = `CORE_SYNC_STAGES;
  localparam int TIMER_W   = `CORE_RESET_TIMER_W;

  localparam logic [TIMER_W-1:0] HOLD_LOAD = TIMER_W'(`CORE_RESET_HOLD);

  logic               download;
  logic [SYNC_N-1:0]  start_sync;
  logic               start_prev;
  logic               start_rise;
  logic [TIMER_W-1:0] hold_timer;
  logic               hold_active;

  //////////////////////////////////////////////////////////////////////////
  // download flag

  // set wins over clear when both pulse together
  always_ff @(posedge clk_74a) begin
    if (rst) begin
      download <= 1'b0;
    end else if (dataslot_requestwrite) begin
      download <= 1'b1;
    end else if (dataslot_allcomplete) begin
      download <= 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // start button

  // key input is async to clk_74a
  // shift in at bit 0, sample the msb
  always_ff @(posedge clk_74a) begin
    if (rst) begin
      start_sync <= '0;
      start_prev <= 1'b0;
    end else begin
      start_sync <= {start_sync[SYNC_N-2:0], cont1_key[START_BIT]};
      start_prev <= start_sync[SYNC_N-1];
    end
  end

  // press only, a held button does not retrigger
  assign start_rise = start_sync[SYNC_N-1] & ~start_prev;

  //////////////////////////////////////////////////////////////////////////
  // reset hold timer

  // loads on a press, then counts down to zero
  always_ff @(posedge clk_74a) begin
    if (rst) begin
      hold_timer <= '0;
    end else if (start_rise) begin
      hold_timer <= HOLD_LOAD;
    end else if (hold_timer != '0) begin
      hold_timer <= hold_timer - 1'b1;
    end
  end

  // high for exactly HOLD_LOAD cycles per press
  assign hold_active = (hold_timer != '0);

  //////////////////////////////////////////////////////////////////////////
  // core reset and status

  // host reset acts in the same cycle
  assign core_reset = ~host_reset_n | download | hold_active;

  assign status = '{
    core_reset:  core_reset,
    hold_active: hold_active,
    download:    download
  };

endmodule

// File: bridge_port.sv
// Bridge bus endpoint in the clk_74a domain.
// Turns loader window writes into a registered load stream and muxes
// read data by address region, with core status in the command region.

`timescale 1ns/1ps

`include "core_settings.svh"

module bridge_port (
  input  logic                         clk_74a,
  input  logic                         rst,
  input  logic [`CORE_BRIDGE_W-1:0]    bridge_addr,
  input  logic                         bridge_wr,
  input  logic [`CORE_BRIDGE_W-1:0]    bridge_wr_data,
  input  bridge_pkg::core_status_t     status,
  output logic [`CORE_BRIDGE_W-1:0]    bridge_rd_data,
  output bridge_pkg::loader_write_t    load_write
);

  localparam int STATUS_W = $bits(bridge_pkg::core_status_t);

  bridge_pkg::bridge_region_e region;

  logic                         load_en_q;
  logic [`CORE_LOAD_ADDR_W-1:0] load_addr_q;
  logic [`CORE_BRIDGE_W-1:0]    load_data_q;

  //////////////////////////////////////////////////////////////////////////
  // region decode

  // upper address byte picks the region
  always_comb begin
    case (bridge_addr[`CORE_BRIDGE_W-1 -: 8])
      `CORE_LOADER_REGION: region = bridge_pkg::region_loader;
      `CORE_CMD_REGION:    region = bridge_pkg::region_cmd;
      default:             region = bridge_pkg::region_other;
    endcase
  end

  //////////////////////////////////////////////////////////////////////////
  // load stream

  // one-cycle strobe per loader write with no back-pressure
  always_ff @(posedge clk_74a) begin
    if (rst) begin
      load_en_q <= 1'b0;
    end else begin
      load_en_q <= bridge_wr && (region == bridge_pkg::region_loader);
    end
  end

  // payload only qualified by load_en_q
  // byte address is the low bits of the bridge address
  always_ff @(posedge clk_74a) begin
    if (bridge_wr && (region == bridge_pkg::region_loader)) begin
      load_addr_q <= bridge_addr[`CORE_LOAD_ADDR_W-1:0];
      load_data_q <= bridge_wr_data;
    end
  end

  assign load_write = '{en: load_en_q, addr: load_addr_q, data: load_data_q};

  //////////////////////////////////////////////////////////////////////////
  // read mux

  // zero latency with no read strobe
  // loader window and other regions read back nothing
  always_comb begin
    bridge_rd_data = '0;
    if (region == bridge_pkg::region_cmd) begin
      // status zero-extended into the low bits
      bridge_rd_data[STATUS_W-1:0] = status;
    end
  end

endmodule

// File: video_pkg.sv
// Pixel and video-timing types for the video output path.
// Used by the video stage and the top level ports.

package video_pkg;

  // 16 bit source pixel, red in the msbs
  typedef struct packed {
    logic [4:0] r5;
    logic [5:0] g6;
    logic [4:0] b5;
  } rgb565_t;

  // 24 bit pixel to the scaler
  typedef struct packed {
    logic [7:0] r8;
    logic [7:0] g8;
    logic [7:0] b8;
  } rgb888_t;

  // one pixel clock worth of source video
  // de high marks active display
  typedef struct packed {
    logic    de;
    logic    hs;
    logic    vs;
    rgb565_t pixel;
  } video_in_t;

endpackage

// File: bridge_pkg.sv
// Bridge-side types: region decode, load stream beat and the status word.
// Shared by the bridge port, the reset controller and the top level.

`include "core_settings.svh"

package bridge_pkg;

  //////////////////////////////////////////////////////////////////////////
  // address region decode

  // decoded from bridge_addr[31:24]
  typedef enum logic [1:0] {
    region_loader,
    region_cmd,
    region_other
  } bridge_region_e;

  //////////////////////////////////////////////////////////////////////////
  // load stream

  // one byte-addressed load beat, valid when en is high
  typedef struct packed {
    logic                         en;
    logic [`CORE_LOAD_ADDR_W-1:0] addr;
    logic [`CORE_BRIDGE_W-1:0]    data;
  } loader_write_t;

  //////////////////////////////////////////////////////////////////////////
  // core status

  // first field is the msb, so download lands in bit 0
  // zero-extended to the bridge width on a read
  typedef struct packed {
    logic core_reset;
    logic hold_active;
    logic download;
  } core_status_t;

endpackage

// File: core_settings.svh
// Shared build-time settings for the core top level.
// Address windows, bus widths and reset timing; included by the packages
// and by every module that needs a width or a window value.

`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// bridge address map

// upper address byte of the loader window
`define CORE_LOADER_REGION 8'h10

// upper address byte of the command / status region
`define CORE_CMD_REGION 8'hF8

// bridge address and data width
`define CORE_BRIDGE_W 32

// byte address width of the load stream
`define CORE_LOAD_ADDR_W 20

////////////////////////////////////////////////////////////////////////////
// core reset timing

// hold timer load value, in clk_74a cycles
`define CORE_RESET_HOLD 65535
`define CORE_RESET_TIMER_W 16

// start button synchronizer depth
`define CORE_SYNC_STAGES 3

`endif
